// File: source/channel_defs.svh
`ifndef CHANNEL_DEFS_SVH
`define CHANNEL_DEFS_SVH

// --------------------------------------------------
// BCH(15,5) code parameters
// --------------------------------------------------
`define BCH_N 15                 // codeword length
`define BCH_K 5                  // message length
`define BCH_GEN 11'b10100110111  // generator polynomial, degree 10
`define BCH_T 3                  // errors corrected per codeword

// --------------------------------------------------
// channel parameters
// --------------------------------------------------
`define DATA_W 8                 // one byte per request
`define LFSR_SEED 16'hB5A3       // must be nonzero

`endif

// File: source/bch_pkg.sv
`default_nettype none

`include "channel_defs.svh"

package bch_pkg;

    typedef logic [`BCH_K-1:0]         message_t;
    typedef logic [`BCH_N-1:0]         codeword_t;
    typedef logic [`BCH_N-`BCH_K-1:0]  parity_t;
    typedef logic [3:0]                distance_t;

    // systematic codeword: message on top, remainder of msg*x^(n-k) mod g below
    function automatic codeword_t bch_codeword_of(input message_t msg);
        codeword_t rem;
        codeword_t gen;
        gen = codeword_t'(`BCH_GEN);
        rem = {msg, parity_t'(0)};
        for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--) begin
            if (rem[i]) begin
                rem = rem ^ (gen << (i - (`BCH_N - `BCH_K)));  // long division step
            end
        end
        return {msg, rem[`BCH_N-`BCH_K-1:0]};
    endfunction

endpackage

`default_nettype wire

// File: source/channel_pkg.sv
`default_nettype none

`include "channel_defs.svh"

package channel_pkg;

    typedef logic [`DATA_W-1:0]    data_t;
    typedef logic [7:0]            err_count_t;
    typedef logic [2*`BCH_N-1:0]   channel_word_t;  // high codeword in the upper half

    typedef struct packed {
        logic       bch_en;     // protect both nibbles
        logic       ber_en;     // inject random bit flips
        err_count_t err_count;  // flips requested
    } channel_cfg_t;

    typedef enum logic [2:0] {
        idle,
        encode_hi,
        encode_lo,
        inject,
        decode_hi,
        decode_lo,
        done
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/bch_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "channel_defs.svh"

module bch_encoder
    import bch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  message_t  message,
    output logic      done,
    output codeword_t codeword
);

    localparam int PAR_W = `BCH_N - `BCH_K;
    localparam int CNT_W = $clog2(`BCH_K);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`BCH_K - 1);
    localparam parity_t GEN_LOW = parity_t'(`BCH_GEN);  // x^10 term is implicit

    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    message_t         msg_r;
    parity_t          parity;
    parity_t          parity_next;
    logic             feedback;

    // msb first through the division register
    assign feedback    = msg_r[`BCH_K-1-bit_cnt] ^ parity[PAR_W-1];
    assign parity_next = {parity[PAR_W-2:0], 1'b0} ^ (feedback ? GEN_LOW : '0);

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin  // last message bit shifted in
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            msg_r  <= message;
            parity <= '0;
        end else if (busy) begin
            parity <= parity_next;
            if (bit_cnt == LAST_BIT) begin
                codeword <= {msg_r, parity_next};
            end
        end
    end

    // the controller waits for done before the next nibble
    assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("bch_encoder: start while busy");

endmodule

`default_nettype wire

// File: source/error_injector.sv
`timescale 1ns/1ps
`default_nettype none

`include "channel_defs.svh"

module error_injector
    import channel_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  channel_word_t word_in,
    input  logic          bch_en,
    input  err_count_t    err_count,
    output logic          done,
    output channel_word_t word_out
);

    localparam int CW_BITS = 2 * `BCH_N;
    localparam err_count_t BITS_BCH = err_count_t'(CW_BITS);
    localparam err_count_t BITS_RAW = err_count_t'(`DATA_W);

    logic [15:0]   lfsr;
    logic          lfsr_fb;
    logic [4:0]    idx;
    logic [4:0]    pos;
    logic          pos_ok;
    channel_word_t flip_bit;
    logic          hit;
    logic          busy;
    logic          bch_mode;
    err_count_t    flips;
    err_count_t    target;
    err_count_t    avail;
    err_count_t    clamped;
    channel_word_t word_r;
    channel_word_t mask;   // bits already flipped

    // x^16 + x^14 + x^13 + x^11 + 1
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign idx     = lfsr[4:0] ^ lfsr[15:11];

    assign avail   = bch_en ? BITS_BCH : BITS_RAW;
    assign clamped = (err_count > avail) ? avail : err_count;

    always_comb begin
        if (bch_mode) begin
            pos    = idx;
            pos_ok = (idx < CW_BITS);   // 30 and 31 are redrawn
        end else begin
            pos    = {2'b00, idx[2:0]};  // low byte only
            pos_ok = 1'b1;
        end
    end

    assign flip_bit = channel_word_t'(1) << pos;
    assign hit      = busy && pos_ok && ((mask & flip_bit) == '0);
    assign word_out = word_r;

    // --------------------------------------------------
    // control and random source
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr  <= `LFSR_SEED;
            busy  <= 1'b0;
            done  <= 1'b0;
            flips <= '0;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};  // free running
            done <= 1'b0;
            if (start) begin
                flips <= '0;
                if (clamped == '0) begin
                    done <= 1'b1;
                end else begin
                    busy <= 1'b1;
                end
            end else if (hit) begin
                flips <= flips + 1'b1;
                if (flips + 1'b1 == target) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            word_r   <= word_in;
            mask     <= '0;
            target   <= clamped;
            bch_mode <= bch_en;
        end else if (hit) begin
            word_r <= word_r ^ flip_bit;
            mask   <= mask | flip_bit;
        end
    end

    // word_in and err_count stay stable in the controller until done
    assert property (@(posedge clk) disable iff (rst)
        done |-> ($countones(word_out ^ word_in) <= int'(err_count)))
        else $error("error_injector: more flips than requested");

endmodule

`default_nettype wire

// File: source/bch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "channel_defs.svh"

module bch_decoder
    import bch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  codeword_t received,
    output logic      done,
    output message_t  message
);

    logic      busy;
    message_t  cand;        // candidate message stepping 0 to 31
    codeword_t rx_r;
    distance_t cand_dist;
    distance_t best_dist;
    message_t  best_msg;
    logic      take;

    assign cand_dist = distance_t'($countones(bch_codeword_of(cand) ^ rx_r));

    // ties keep the earlier candidate
    assign take = (cand_dist < best_dist);

    // --------------------------------------------------
    // candidate sweep
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cand <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cand <= '0;
            end else if (busy) begin
                cand <= cand + 1'b1;
                if (cand == '1) begin  // 32nd candidate checked
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // best match tracking
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            rx_r      <= received;
            best_dist <= '1;
            best_msg  <= '0;
        end else if (busy) begin
            if (take) begin
                best_dist <= cand_dist;
                best_msg  <= cand;
            end
            if (cand == '1) begin
                message <= take ? cand : best_msg;  // last candidate may still win
            end
        end
    end

endmodule

`default_nettype wire

// File: source/channel_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "channel_defs.svh"

module channel_controller
    import bch_pkg::*;
    import channel_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  data_t         data_in,
    input  channel_cfg_t  cfg,
    input  logic          data_in_valid,
    output data_t         data_out,
    output logic          data_out_valid,
    // encoder
    output logic          enc_start,
    output message_t      enc_message,
    input  logic          enc_done,
    input  codeword_t     enc_codeword,
    // error injector
    output logic          inj_start,
    output channel_word_t inj_word,
    output logic          inj_bch_en,
    output err_count_t    inj_count,
    input  logic          inj_done,
    input  channel_word_t inj_word_out,
    // decoder
    output logic          dec_start,
    output codeword_t     dec_received,
    input  logic          dec_done,
    input  message_t      dec_message
);

    localparam int NIB_W = `DATA_W / 2;
    localparam int PAD_W = 2 * `BCH_N - `DATA_W;

    ctrl_state_t      state;
    channel_cfg_t     cfg_r;
    data_t            data_r;
    channel_word_t    chan_word;   // what travels over the channel
    logic [NIB_W-1:0] nib_hi;
    logic [NIB_W-1:0] nib_lo;
    logic             accept;
    data_t            result;

    // strobes during processing are dropped
    assign accept = data_in_valid && (state == idle || state == done);

    assign inj_word   = chan_word;
    assign inj_bch_en = cfg_r.bch_en;
    assign inj_count  = cfg_r.err_count;

    assign dec_received = (state == decode_lo) ? chan_word[`BCH_N-1:0]
                                               : chan_word[2*`BCH_N-1:`BCH_N];

    assign result = cfg_r.bch_en ? {nib_hi, nib_lo} : chan_word[`DATA_W-1:0];

    // --------------------------------------------------
    // FSM and phase strobes
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= idle;
            cfg_r          <= '0;
            enc_start      <= 1'b0;
            inj_start      <= 1'b0;
            dec_start      <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            enc_start <= 1'b0;
            inj_start <= 1'b0;
            dec_start <= 1'b0;
            if (accept) begin
                cfg_r          <= cfg;
                data_out_valid <= 1'b0;
                if (cfg.bch_en) begin
                    state     <= encode_hi;
                    enc_start <= 1'b1;
                end else if (cfg.ber_en) begin
                    state     <= inject;
                    inj_start <= 1'b1;
                end else begin
                    state <= done;  // plain pass-through
                end
            end else begin
                case (state)
                    encode_hi: if (enc_done) begin
                        state     <= encode_lo;
                        enc_start <= 1'b1;
                    end
                    encode_lo: if (enc_done) begin
                        if (cfg_r.ber_en) begin
                            state     <= inject;
                            inj_start <= 1'b1;
                        end else begin
                            state     <= decode_hi;
                            dec_start <= 1'b1;
                        end
                    end
                    inject: if (inj_done) begin
                        if (cfg_r.bch_en) begin
                            state     <= decode_hi;
                            dec_start <= 1'b1;
                        end else begin
                            state <= done;
                        end
                    end
                    decode_hi: if (dec_done) begin
                        state     <= decode_lo;
                        dec_start <= 1'b1;
                    end
                    decode_lo: if (dec_done) begin
                        state <= done;
                    end
                    done: data_out_valid <= 1'b1;  // one cycle after entry
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            data_r      <= data_in;
            chan_word   <= {{PAD_W{1'b0}}, data_in};
            enc_message <= message_t'(data_in[`DATA_W-1:NIB_W]);  // high nibble first
        end else begin
            case (state)
                encode_hi: if (enc_done) begin
                    chan_word[2*`BCH_N-1:`BCH_N] <= enc_codeword;
                    enc_message <= message_t'(data_r[NIB_W-1:0]);
                end
                encode_lo: if (enc_done) begin
                    chan_word[`BCH_N-1:0] <= enc_codeword;
                end
                inject: if (inj_done) begin
                    chan_word <= inj_word_out;
                end
                decode_hi: if (dec_done) begin
                    nib_hi <= dec_message[NIB_W-1:0];
                end
                decode_lo: if (dec_done) begin
                    nib_lo <= dec_message[NIB_W-1:0];
                end
                done: if (!data_out_valid) begin
                    data_out <= result;
                end
                default: ;
            endcase
        end
    end

    // valid must drop before any new phase starts
    assert property (@(posedge clk) disable iff (rst) data_out_valid |-> state == done)
        else $error("channel_controller: data_out_valid outside done");

endmodule

`default_nettype wire

// File: source/channel_sim_top.sv
`timescale 1ns/1ps
`default_nettype none

module channel_sim_top
    import bch_pkg::*;
    import channel_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  data_t        data_in,
    input  channel_cfg_t cfg,
    input  logic         data_in_valid,
    output data_t        data_out,
    output logic         data_out_valid
);

    logic          enc_start;
    message_t      enc_message;
    logic          enc_done;
    codeword_t     enc_codeword;
    logic          inj_start;
    channel_word_t inj_word;
    logic          inj_bch_en;
    err_count_t    inj_count;
    logic          inj_done;
    channel_word_t inj_word_out;
    logic          dec_start;
    codeword_t     dec_received;
    logic          dec_done;
    message_t      dec_message;

    channel_controller u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .data_in        (data_in),
        .cfg            (cfg),
        .data_in_valid  (data_in_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .enc_start      (enc_start),
        .enc_message    (enc_message),
        .enc_done       (enc_done),
        .enc_codeword   (enc_codeword),
        .inj_start      (inj_start),
        .inj_word       (inj_word),
        .inj_bch_en     (inj_bch_en),
        .inj_count      (inj_count),
        .inj_done       (inj_done),
        .inj_word_out   (inj_word_out),
        .dec_start      (dec_start),
        .dec_received   (dec_received),
        .dec_done       (dec_done),
        .dec_message    (dec_message)
    );

    bch_encoder u_enc (
        .clk      (clk),
        .rst      (rst),
        .start    (enc_start),
        .message  (enc_message),
        .done     (enc_done),
        .codeword (enc_codeword)
    );

    error_injector u_inj (
        .clk       (clk),
        .rst       (rst),
        .start     (inj_start),
        .word_in   (inj_word),
        .bch_en    (inj_bch_en),
        .err_count (inj_count),
        .done      (inj_done),
        .word_out  (inj_word_out)
    );

    bch_decoder u_dec (
        .clk      (clk),
        .rst      (rst),
        .start    (dec_start),
        .received (dec_received),
        .done     (dec_done),
        .message  (dec_message)
    );

endmodule

`default_nettype wire

// File: sim/tb_channel_sim.sv
`timescale 1ns/1ps
`default_nettype none

`include "channel_defs.svh"

module tb_channel_sim
    import channel_pkg::*;
();

    // 20 + 10 + 30 + 11 + 3 requests
    localparam int TXN_COUNT   = 74;
    // two 6-cycle encodes, injection and two 33-cycle decodes, with margin
    localparam int TXN_BUDGET  = 270;
    localparam int CYCLE_LIMIT = 16 + TXN_COUNT * TXN_BUDGET;

    logic         clk;
    logic         rst;
    data_t        data_in;
    channel_cfg_t cfg;
    logic         data_in_valid;
    data_t        data_out;
    logic         data_out_valid;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     cycles;

    channel_sim_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .data_in        (data_in),
        .cfg            (cfg),
        .data_in_valid  (data_in_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the DUT did not finish within %0d cycles", cycles);
        $display("Verification failed");
        $finish;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input err_count_t exp,
                               input err_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    task automatic send_request(input data_t d, input logic bch, input logic ber,
                                input err_count_t n);
        channel_cfg_t c;
        c.bch_en    = bch;
        c.ber_en    = ber;
        c.err_count = n;
        @(posedge clk);
        data_in       <= d;
        cfg           <= c;
        data_in_valid <= 1'b1;
        @(posedge clk);
        data_in_valid <= 1'b0;  // one-cycle strobe
    endtask

    task automatic wait_result();
        @(negedge clk);
        while (data_out_valid !== 1'b1) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests++;
        if (errors == errs_at_start)
            $display("%-16s ok", name);
        else
            $display("%-16s %0d errors", name, errors - errs_at_start);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic pass_through_bytes();
        int    start_errs;
        data_t d;
        start_errs = errors;
        for (int i = 0; i < 20; i++) begin
            d = data_t'($random(seed));
            send_request(d, 1'b0, 1'b0, '0);
            wait_result();
            check_data("pass_through", d, data_out);
        end
        report_test("pass_through", start_errs);
    endtask

    task automatic bch_without_errors();
        int    start_errs;
        data_t d;
        start_errs = errors;
        for (int i = 0; i < 10; i++) begin
            d = data_t'($random(seed));
            send_request(d, 1'b1, 1'b0, '0);
            wait_result();
            check_data("bch_clean", d, data_out);
        end
        report_test("bch_clean", start_errs);
    endtask

    task automatic correct_random_errors();
        int         start_errs;
        data_t      d;
        err_count_t n;
        start_errs = errors;
        for (int i = 0; i < 30; i++) begin
            d = data_t'($random(seed));
            n = err_count_t'(1 + {$random(seed)} % 3);  // 1 to 3 flips over both codewords
            send_request(d, 1'b1, 1'b1, n);
            wait_result();
            check_data("correction", d, data_out);
        end
        report_test("correction", start_errs);
    endtask

    task automatic count_raw_errors();
        int         start_errs;
        data_t      d;
        err_count_t exp;
        start_errs = errors;
        for (int n = 0; n <= 10; n++) begin
            d   = data_t'($random(seed));
            exp = (n > `DATA_W) ? err_count_t'(`DATA_W) : err_count_t'(n);
            send_request(d, 1'b0, 1'b1, err_count_t'(n));
            wait_result();
            check_count("raw_errors", exp, err_count_t'($countones(data_out ^ d)));
        end
        report_test("raw_errors", start_errs);
    endtask

    task automatic protocol_rules();
        int    start_errs;
        data_t first;
        data_t second;
        start_errs = errors;
        @(negedge clk);
        checks++;
        if (data_out_valid !== 1'b0) begin
            errors++;
            $display("data_out_valid is high right after reset");
        end
        first = data_t'($random(seed));
        send_request(first, 1'b1, 1'b0, '0);
        wait_result();
        check_data("protocol", first, data_out);
        second = data_t'($random(seed));
        send_request(second, 1'b1, 1'b1, err_count_t'(2));
        @(negedge clk);
        checks++;
        if (data_out_valid !== 1'b0) begin
            errors++;
            $display("data_out_valid did not fall after a new accepted request");
        end
        send_request(~second, 1'b0, 1'b0, '0);  // arrives mid-encode, must be dropped
        wait_result();
        check_data("protocol", second, data_out);
        report_test("protocol", start_errs);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        rst           = 1'b1;
        data_in       = '0;
        cfg           = '0;
        data_in_valid = 1'b0;
        seed          = 43;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        protocol_rules();
        pass_through_bytes();
        bch_without_errors();
        correct_random_errors();
        count_raw_errors();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: channel_sim.f
+incdir+source
source/bch_pkg.sv
source/channel_pkg.sv
source/bch_encoder.sv
source/error_injector.sv
source/bch_decoder.sv
source/channel_controller.sv
source/channel_sim_top.sv
sim/tb_channel_sim.sv

// File: Makefile
# Verilator build for the channel simulation testbench

VERILATOR ?= verilator
TOP       ?= tb_channel_sim
FILELIST  ?= channel_sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM       ?= ./$(OBJ_DIR)/V$(TOP)
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
